// File: Makefile
SRCS := $(wildcard hdl/*.sv) tests/obj_tb.sv

.PHONY: run clean

obj_dir/Vobj_tb: $(SRCS) tb.f
	verilator --binary -j 0 -Wno-fatal --top-module obj_tb -f tb.f

# The ROM image is loaded by file name, so the simulation runs in tests/
run: obj_dir/Vobj_tb
	@out="$$(cd tests && ../obj_dir/Vobj_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: hdl/obj_draw.sv
// -------------------------------------------------------------------------
// Object drawer
// Fetches two graphics words per object line and writes the opaque
// pixels into the line buffer, one pixel per cycle
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module obj_draw (
    input  logic                        clk,
    input  logic                        rst,
    // Draw command
    input  logic                        dr_start,
    output logic                        dr_busy,
    input  logic [obj_pkg::lb_aw-1:0]   dr_xpos,
    input  obj_pkg::obj_offset_u        dr_offset,
    input  logic [5:0]                  dr_pal,
    input  logic [1:0]                  dr_prio,  // Held for a later mixer stage
    // Graphics ROM
    output logic [obj_pkg::gfx_aw-1:0]  gfx_addr,
    input  logic [obj_pkg::data_w-1:0]  gfx_data,
    // Line buffer
    output logic                        lb_we,
    output logic [obj_pkg::lb_aw-1:0]   lb_addr,
    output logic [obj_pkg::pix_w-1:0]   lb_data
);

    logic [3:0]                  cnt;
    logic [obj_pkg::data_w-1:0]  sh;     // Current word, shifted per pixel
    logic [obj_pkg::lb_aw-1:0]   xcur;
    logic [5:0]                  pal;
    logic                        hflip;
    logic [3:0]                  pix;
    logic                        act;
    logic [obj_pkg::gfx_aw-1:0]  base;

    assign base = dr_offset.fld.gfx_addr[obj_pkg::gfx_aw-1:0];

    // Pixels go out from the third busy cycle on
    assign act     = dr_busy && cnt >= 4'd2;
    assign pix     = hflip ? sh[3:0] : sh[15:12];
    assign lb_we   = act && pix != 4'd0; // Colour 0 is transparent
    assign lb_addr = xcur;
    assign lb_data = {pal, pix};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dr_busy <= 1'b0;
            cnt     <= '0;
        end else if (dr_start) begin
            dr_busy <= 1'b1;
            cnt     <= '0;
        end else if (dr_busy) begin
            cnt <= cnt + 4'd1;
            if (cnt == obj_pkg::obj_width + 1)
                dr_busy <= 1'b0; // Last pixel written
        end
    end

    always_ff @(posedge clk) begin
        if (dr_start) begin
            xcur     <= dr_xpos;
            pal      <= dr_pal;
            hflip    <= dr_offset.fld.hflip;
            gfx_addr <= dr_offset.fld.hflip ? base + 1'b1 : base; // Right word first
        end else if (dr_busy) begin
            if (cnt == 4'd0)
                gfx_addr <= hflip ? gfx_addr - 1'b1 : gfx_addr + 1'b1;
            // Second word stays on gfx_data once addressed
            if (cnt == 4'd1 || cnt == 1 + obj_pkg::obj_width / 2)
                sh <= gfx_data;
            else if (act)
                sh <= hflip ? sh >> 4 : sh << 4;
            if (act)
                xcur <= xcur + 1'b1; // Wraps at 512
        end
    end

endmodule

// File: hdl/obj_line_buf.sv
// -------------------------------------------------------------------------
// Double line buffer
// Drawer fills one bank while video reads the other, banks swap at
// hstart, every read clears the entry it returns
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module obj_line_buf (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        hstart,
    // Drawer side
    input  logic                        lb_we,
    input  logic [obj_pkg::lb_aw-1:0]   lb_addr,
    input  logic [obj_pkg::pix_w-1:0]   lb_data,
    // Video side
    input  logic [obj_pkg::lb_aw-1:0]   pix_x,
    output logic [obj_pkg::pix_w-1:0]   pix_out
);

    logic [obj_pkg::pix_w-1:0] mem [2][2**obj_pkg::lb_aw];
    logic                      rd_bank;

    // Both banks start blank
    initial begin
        for (int b = 0; b < 2; b++)
            for (int i = 0; i < 2**obj_pkg::lb_aw; i++)
                mem[b][i] = '0;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            rd_bank <= 1'b0;
        else if (hstart)
            rd_bank <= ~rd_bank;
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (b == int'(rd_bank))
                mem[b][pix_x] <= '0; // Clear behind the read
            else if (lb_we)
                mem[b][lb_addr] <= lb_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            pix_out <= '0;
        else
            pix_out <= mem[rd_bank][pix_x];
    end

endmodule

// File: hdl/obj_pkg.sv
// -------------------------------------------------------------------------
// Shared definitions for the object line engine
// Object table layout and word indexes, end marker, visible range,
// graphics and line buffer sizes, scanner states, offset word union
// -------------------------------------------------------------------------

package obj_pkg;

    // Object table
    localparam int obj_count = 16;
    localparam int obj_aw    = 4;
    localparam int word_aw   = 3;
    localparam int tbl_aw    = 7;
    localparam int data_w    = 16;

    localparam logic [word_aw-1:0] w_vpos    = 3'd0; // Top low byte, bottom high byte
    localparam logic [word_aw-1:0] w_xpos    = 3'd1;
    localparam logic [word_aw-1:0] w_pitch   = 3'd2; // Signed, added per line
    localparam logic [word_aw-1:0] w_offset  = 3'd3;
    localparam logic [word_aw-1:0] w_attr    = 3'd4; // Palette 13:8, priority 1:0
    localparam logic [word_aw-1:0] w_scratch = 3'd7; // Running offset

    localparam logic [obj_aw-1:0] last_obj = obj_aw'(obj_count - 1);

    localparam logic [7:0] end_mark  = 8'hf0;
    localparam int         vis_lines = 224;

    // Graphics and pixels
    localparam int gfx_aw    = 5;
    localparam int obj_width = 8;  // Two ROM words
    localparam int pix_w     = 10; // Palette and colour
    localparam int lb_aw     = 9;

    localparam logic [lb_aw-1:0] flip_base = lb_aw'(vis_lines - 1);

    // Scanner states
    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_read  = 2'd1;
    localparam logic [1:0] st_write = 2'd2;
    localparam logic [1:0] st_draw  = 2'd3;

    typedef struct packed {
        logic        hflip;
        logic [14:0] gfx_addr;
    } obj_offset_s;

    // Offset word, added to as a whole and decoded by the drawer
    typedef union packed {
        logic [data_w-1:0] word;
        obj_offset_s       fld;
    } obj_offset_u;

endpackage

// File: hdl/obj_scan.sv
// -------------------------------------------------------------------------
// Object scanner
// Walks the object table at line start, selects objects on the line,
// updates the scratch offset and issues one draw command per object
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module obj_scan (
    input  logic                        clk,
    input  logic                        rst,
    // Object table
    output logic [obj_pkg::tbl_aw-1:0]  tbl_addr,
    output logic                        tbl_we,
    output logic [obj_pkg::data_w-1:0]  tbl_din,
    input  logic [obj_pkg::data_w-1:0]  tbl_dout,
    input  logic                        tbl_wait,
    // Draw commands
    output logic                        dr_start,
    input  logic                        dr_busy,
    output logic [obj_pkg::lb_aw-1:0]   dr_xpos,
    output obj_pkg::obj_offset_u        dr_offset,
    output logic [5:0]                  dr_pal,
    output logic [1:0]                  dr_prio,
    // Video timing
    input  logic                        hstart,
    input  logic [8:0]                  vrender,
    input  logic                        flip
);

    logic [1:0]                  st;
    logic [obj_pkg::obj_aw-1:0]  cur_obj;
    logic [obj_pkg::word_aw-1:0] idx;     // Word being addressed
    logic [obj_pkg::word_aw-1:0] idx_q;   // Word on tbl_dout
    logic                        vld;
    logic                        iss_done;
    logic                        first;
    logic                        go_draw;

    logic [obj_pkg::lb_aw-1:0]   xpos;
    logic [obj_pkg::data_w-1:0]  pitch;   // Two's complement
    logic [obj_pkg::data_w-1:0]  off_start;
    logic [5:0]                  pal;
    logic [1:0]                  prio;
    obj_pkg::obj_offset_u        line_off;

    logic [8:0] vrf;
    logic [7:0] top;
    logic [7:0] bottom;
    logic       inzone;
    logic       badobj;

    assign vrf    = flip ? obj_pkg::flip_base - vrender : vrender;
    assign top    = tbl_dout[7:0];
    assign bottom = tbl_dout[15:8];
    assign inzone = vrf[7:0] >= top && bottom > vrf[7:0];
    assign badobj = top >= bottom;

    assign tbl_addr = {cur_obj, idx};
    assign tbl_we   = st == obj_pkg::st_write;
    assign tbl_din  = line_off.word + pitch; // Next line offset
    assign go_draw  = st == obj_pkg::st_draw && !dr_busy && !dr_start;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= obj_pkg::st_idle;
            cur_obj  <= '0;
            idx      <= obj_pkg::w_vpos;
            idx_q    <= obj_pkg::w_vpos;
            vld      <= 1'b0;
            iss_done <= 1'b0;
            dr_start <= 1'b0;
        end else begin
            dr_start <= 1'b0;
            case (st)
                obj_pkg::st_idle: begin
                    cur_obj  <= '0;
                    idx      <= obj_pkg::w_vpos;
                    vld      <= 1'b0;
                    iss_done <= 1'b0;
                    if (hstart && vrf < obj_pkg::vis_lines)
                        st <= obj_pkg::st_read;
                end
                obj_pkg::st_read: begin
                    // Issue side, one word per cycle unless the CPU has the port
                    if (!iss_done) begin
                        vld <= !tbl_wait;
                        if (!tbl_wait) begin
                            idx_q <= idx;
                            if (idx == obj_pkg::w_scratch)
                                iss_done <= 1'b1;
                            else if (idx == obj_pkg::w_attr)
                                idx <= obj_pkg::w_scratch;
                            else
                                idx <= idx + 3'd1;
                        end
                    end else begin
                        vld <= 1'b0;
                    end
                    // Data side
                    if (vld && idx_q == obj_pkg::w_vpos) begin
                        if (bottom >= obj_pkg::end_mark) begin
                            st <= obj_pkg::st_idle; // End of list
                        end else if (!inzone || badobj) begin
                            idx      <= obj_pkg::w_vpos;
                            vld      <= 1'b0;
                            iss_done <= 1'b0;
                            if (cur_obj == obj_pkg::last_obj)
                                st <= obj_pkg::st_idle;
                            else
                                cur_obj <= cur_obj + 1'b1;
                        end
                    end
                    if (vld && idx_q == obj_pkg::w_scratch)
                        st <= obj_pkg::st_write;
                end
                obj_pkg::st_write: begin
                    if (!tbl_wait)
                        st <= obj_pkg::st_draw; // Scratch word updated
                end
                default: begin
                    if (go_draw) begin
                        dr_start <= 1'b1;
                        idx      <= obj_pkg::w_vpos;
                        vld      <= 1'b0;
                        iss_done <= 1'b0;
                        if (cur_obj == obj_pkg::last_obj) begin
                            st <= obj_pkg::st_idle;
                        end else begin
                            cur_obj <= cur_obj + 1'b1;
                            st      <= obj_pkg::st_read;
                        end
                    end
                end
            endcase
        end
    end

    // Descriptor capture and draw command
    always_ff @(posedge clk) begin
        if (vld) begin
            case (idx_q)
                obj_pkg::w_vpos:    first <= top == vrf[7:0];
                obj_pkg::w_xpos:    xpos <= tbl_dout[8:0];
                obj_pkg::w_pitch:   pitch <= tbl_dout;
                obj_pkg::w_offset:  off_start <= tbl_dout;
                obj_pkg::w_attr: begin
                    pal  <= tbl_dout[13:8];
                    prio <= tbl_dout[1:0];
                end
                obj_pkg::w_scratch: line_off.word <= first ? off_start : tbl_dout;
                default: ;
            endcase
        end
        if (go_draw) begin
            dr_xpos   <= xpos;
            dr_offset <= line_off;
            dr_pal    <= pal;
            dr_prio   <= prio;
        end
    end

endmodule

// File: hdl/obj_sys.sv
// -------------------------------------------------------------------------
// Object engine top level
// Object table with arbiter, scanner, drawer, graphics ROM, line buffer
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module obj_sys (
    input  logic                        clk,
    input  logic                        rst,
    // CPU write port
    input  logic                        cpu_we,
    input  logic [obj_pkg::tbl_aw-1:0]  cpu_addr,
    input  logic [obj_pkg::data_w-1:0]  cpu_din,
    // Video timing
    input  logic                        hstart,
    input  logic [8:0]                  vrender,
    input  logic                        flip,
    // Pixel readout
    input  logic [obj_pkg::lb_aw-1:0]   pix_x,
    output logic [obj_pkg::pix_w-1:0]   pix_out
);

    logic [obj_pkg::tbl_aw-1:0]  tbl_addr;
    logic                        tbl_we;
    logic [obj_pkg::data_w-1:0]  tbl_din;
    logic [obj_pkg::data_w-1:0]  tbl_dout;
    logic                        tbl_wait;

    logic                        dr_start;
    logic                        dr_busy;
    logic [obj_pkg::lb_aw-1:0]   dr_xpos;
    obj_pkg::obj_offset_u        dr_offset;
    logic [5:0]                  dr_pal;
    logic [1:0]                  dr_prio;

    logic [obj_pkg::gfx_aw-1:0]  gfx_addr;
    logic [obj_pkg::data_w-1:0]  gfx_data;

    logic                        lb_we;
    logic [obj_pkg::lb_aw-1:0]   lb_addr;
    logic [obj_pkg::pix_w-1:0]   lb_data;

    logic [obj_pkg::data_w-1:0]  gfx_rom [2**obj_pkg::gfx_aw];

    initial $readmemh("obj_gfx.hex", gfx_rom);

    always_ff @(posedge clk) begin
        gfx_data <= gfx_rom[gfx_addr]; // One cycle latency
    end

    obj_table_arb u_table (
        .clk       (clk),
        .rst       (rst),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_din   (cpu_din),
        .scan_addr (tbl_addr),
        .scan_we   (tbl_we),
        .scan_din  (tbl_din),
        .scan_dout (tbl_dout),
        .scan_wait (tbl_wait)
    );

    obj_scan u_scan (
        .clk       (clk),
        .rst       (rst),
        .tbl_addr  (tbl_addr),
        .tbl_we    (tbl_we),
        .tbl_din   (tbl_din),
        .tbl_dout  (tbl_dout),
        .tbl_wait  (tbl_wait),
        .dr_start  (dr_start),
        .dr_busy   (dr_busy),
        .dr_xpos   (dr_xpos),
        .dr_offset (dr_offset),
        .dr_pal    (dr_pal),
        .dr_prio   (dr_prio),
        .hstart    (hstart),
        .vrender   (vrender),
        .flip      (flip)
    );

    obj_draw u_draw (
        .clk       (clk),
        .rst       (rst),
        .dr_start  (dr_start),
        .dr_busy   (dr_busy),
        .dr_xpos   (dr_xpos),
        .dr_offset (dr_offset),
        .dr_pal    (dr_pal),
        .dr_prio   (dr_prio),
        .gfx_addr  (gfx_addr),
        .gfx_data  (gfx_data),
        .lb_we     (lb_we),
        .lb_addr   (lb_addr),
        .lb_data   (lb_data)
    );

    obj_line_buf u_line_buf (
        .clk       (clk),
        .rst       (rst),
        .hstart    (hstart),
        .lb_we     (lb_we),
        .lb_addr   (lb_addr),
        .lb_data   (lb_data),
        .pix_x     (pix_x),
        .pix_out   (pix_out)
    );

endmodule

// File: hdl/obj_table_arb.sv
// -------------------------------------------------------------------------
// Object table RAM shared by the CPU and the object scanner
// CPU has priority, scanner is told to repeat its access
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module obj_table_arb (
    input  logic                        clk,
    input  logic                        rst,
    // CPU side
    input  logic                        cpu_we,
    input  logic [obj_pkg::tbl_aw-1:0]  cpu_addr,
    input  logic [obj_pkg::data_w-1:0]  cpu_din,
    // Scanner side
    input  logic [obj_pkg::tbl_aw-1:0]  scan_addr,
    input  logic                        scan_we,
    input  logic [obj_pkg::data_w-1:0]  scan_din,
    output logic [obj_pkg::data_w-1:0]  scan_dout,
    output logic                        scan_wait
);

    logic [obj_pkg::data_w-1:0] mem [2**obj_pkg::tbl_aw];

    logic [obj_pkg::tbl_aw-1:0] port_addr;
    logic [obj_pkg::data_w-1:0] port_din;
    logic                       port_we;

    // Single port, CPU takes it whenever it writes
    assign port_addr = cpu_we ? cpu_addr : scan_addr;
    assign port_din  = cpu_we ? cpu_din  : scan_din;
    assign port_we   = cpu_we | scan_we;

    assign scan_wait = cpu_we; // Scanner access lost this cycle

    always_ff @(posedge clk) begin
        if (port_we)
            mem[port_addr] <= port_din;
    end

    // Registered read, valid the cycle after the address
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_dout <= '0;
        end else begin
            scan_dout <= mem[port_addr];
        end
    end

endmodule

// File: tb.f
hdl/obj_pkg.sv
hdl/obj_table_arb.sv
hdl/obj_scan.sv
hdl/obj_draw.sv
hdl/obj_line_buf.sv
hdl/obj_sys.sv
tests/obj_tb.sv

// File: tests/obj_gfx.hex
// Graphics ROM, one 16-bit word per line from address 0 up
// Four 4-bit pixels per word, leftmost pixel in the high nibble
1203
4056
0780
9abc
def0
0102
3004
5600
0078
9a0b
cd0e
f001
2340
0567
8090
ab0c
0d0e
f100
2003
0405
6070
8009
0a0b
c0d0
e0f1
1111
2202
0330
4004
0550
6600
0077

// File: tests/obj_tb.sv
// --------------------------------------------------------------------------
// Testbench for the object line engine
// Table of line cases with object descriptors, reference model of one
// line, CPU collision writes, full line readout and clear check
// --------------------------------------------------------------------------

`timescale 1ns/100ps

module obj_tb;

    localparam int n_cases   = 6;
    localparam int line_len  = 512;
    localparam int cyc_limit = (n_cases + 1) * 3 * line_len + 100;

    logic       clk;
    logic       rst;
    logic       cpu_we;
    logic [6:0] cpu_addr;
    logic [15:0] cpu_din;
    logic       hstart;
    logic [8:0] vrender;
    logic       flip;
    logic [8:0] pix_x;
    logic [9:0] pix_out;

    // Stimulus table
    logic [8:0]  case_vr    [n_cases];
    logic        case_flip  [n_cases];
    int          case_first [n_cases];
    int          case_cnt   [n_cases];
    logic [15:0] obj_tab    [64][5]; // vpos, xpos, pitch, offset, attr
    int          n_objs;
    int          n_defined;

    // Reference model state
    logic [15:0] scratch_ref [16];
    logic [15:0] gfx_ref     [32];
    logic [9:0]  exp_line    [line_len];

    int errors;
    int checks;
    int cycles;

    obj_sys dut0 (
        .clk      (clk),
        .rst      (rst),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .hstart   (hstart),
        .vrender  (vrender),
        .flip     (flip),
        .pix_x    (pix_x),
        .pix_out  (pix_out)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cyc_limit) begin
            $display("Timeout, run did not finish within %0d cycles", cyc_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic begin_case(input logic [8:0] vr, input logic fl);
        case_vr[n_defined]    = vr;
        case_flip[n_defined]  = fl;
        case_first[n_defined] = n_objs;
        case_cnt[n_defined]   = 0;
        n_defined++;
    endtask

    task automatic add_obj(input logic [15:0] vpos, input logic [15:0] xpos,
                           input logic [15:0] pitch, input logic [15:0] offset,
                           input logic [15:0] attr);
        obj_tab[n_objs][0] = vpos;
        obj_tab[n_objs][1] = xpos;
        obj_tab[n_objs][2] = pitch;
        obj_tab[n_objs][3] = offset;
        obj_tab[n_objs][4] = attr;
        n_objs++;
        case_cnt[n_defined-1]++;
    endtask

    task automatic fill_cases;
        n_objs    = 0;
        n_defined = 0;
        // First line of obj 0, then skipped, bad and post end mark objects
        begin_case(9'd10, 1'b0);
        add_obj(16'h120a, 16'd40, 16'd2, 16'h0000, 16'h0501);
        add_obj(16'h3c32, 16'd100, 16'd0, 16'h0004, 16'h0600);
        add_obj(16'h141e, 16'd120, 16'd0, 16'h0006, 16'h0700);
        add_obj(16'hf000, 16'd0, 16'd0, 16'h0000, 16'h0000);
        add_obj(16'h1408, 16'd200, 16'd0, 16'h0008, 16'h0800);
        // Second line from scratch, overlap with a later object
        begin_case(9'd11, 1'b0);
        add_obj(16'h120a, 16'd40, 16'd2, 16'h0000, 16'h0501);
        add_obj(16'h1a0b, 16'd44, 16'd0, 16'h000a, 16'h0902);
        // Third line, hflip object with negative pitch, overlaps
        begin_case(9'd12, 1'b0);
        add_obj(16'h120a, 16'd40, 16'd2, 16'h0000, 16'h0501);
        add_obj(16'h200c, 16'd300, 16'hfffe, 16'h8006, 16'h0a00);
        add_obj(16'h100c, 16'd302, 16'd0, 16'h001e, 16'h0b00);
        // Screen flip, vrf 100, x wraps past 511
        begin_case(9'd123, 1'b1);
        add_obj(16'h6e64, 16'd508, 16'd1, 16'h801f, 16'h0c00);
        // Line outside the visible range
        begin_case(9'd230, 1'b0);
        add_obj(16'heae4, 16'd10, 16'd0, 16'h0002, 16'h0d00);
        // Flipped next line, vrf 101, uses the scratch word
        begin_case(9'd122, 1'b1);
        add_obj(16'h6e64, 16'd508, 16'd1, 16'h801f, 16'h0c00);
        add_obj(16'h6a65, 16'd60, 16'd0, 16'h0010, 16'h0e00);
    endtask

    function automatic logic [3:0] ref_pixel(input int base, input logic hf, input int k);
        int          kk;
        logic [15:0] word;
        kk   = hf ? 7 - k : k;
        word = gfx_ref[(base + kk / 4) % 32];
        return 4'((word >> (12 - 4 * (kk % 4))) & 16'h000f);
    endfunction

    // Expected line from the descriptor rules, in table order
    task automatic build_expected(input int c);
        int          vrf;
        int          idx;
        logic [7:0]  v8;
        logic [7:0]  top;
        logic [7:0]  bot;
        logic [15:0] off;
        logic [15:0] desc [5];
        logic [3:0]  p;
        for (int x = 0; x < line_len; x++)
            exp_line[x] = '0;
        vrf = case_flip[c] ? (223 - int'(case_vr[c])) & 511 : int'(case_vr[c]);
        if (vrf >= 224)
            return;
        v8 = 8'(vrf);
        for (int i = 0; i < 16; i++) begin
            if (i >= case_cnt[c])
                break; // Terminator written after the list
            idx = case_first[c] + i;
            for (int w = 0; w < 5; w++)
                desc[w] = obj_tab[idx][w];
            top = desc[0][7:0];
            bot = desc[0][15:8];
            if (bot >= 8'hf0)
                break;
            if (!(v8 >= top && bot > v8))
                continue;
            off = (top == v8) ? desc[3] : scratch_ref[i];
            scratch_ref[i] = off + desc[2];
            for (int k = 0; k < 8; k++) begin
                p = ref_pixel(int'(off[4:0]), off[15], k);
                if (p != 4'd0)
                    exp_line[(int'(desc[1][8:0]) + k) % line_len] = {desc[4][13:8], p};
            end
        end
    endtask

    task automatic cpu_write(input int addr, input logic [15:0] data);
        @(posedge clk);
        cpu_we   <= 1'b1;
        cpu_addr <= 7'(addr);
        cpu_din  <= data;
    endtask

    task automatic load_case(input int c);
        for (int i = 0; i < case_cnt[c]; i++)
            for (int w = 0; w < 5; w++)
                cpu_write(i * 8 + w, obj_tab[case_first[c] + i][w]);
        if (case_cnt[c] < 16)
            cpu_write(case_cnt[c] * 8, 16'hf000); // End of list
        @(posedge clk);
        cpu_we <= 1'b0;
    endtask

    task automatic pulse_hstart(input logic [8:0] vr, input logic fl);
        @(posedge clk);
        hstart  <= 1'b1;
        vrender <= vr;
        flip    <= fl;
        pix_x   <= '0; // Video readout restarts at x 0
        @(posedge clk);
        hstart <= 1'b0;
    endtask

    // One line period with random writes to the unused words 5 and 6
    task automatic run_line;
        for (int c = 0; c < line_len; c++) begin
            @(posedge clk);
            if (c < 300 && $urandom % 3 == 0) begin
                cpu_we   <= 1'b1;
                cpu_addr <= 7'(($urandom % 16) * 8 + 5 + $urandom % 2);
                cpu_din  <= 16'($urandom);
            end else begin
                cpu_we <= 1'b0;
            end
        end
        @(posedge clk);
        cpu_we <= 1'b0;
    endtask

    // pix_x is already 0 when the banks swap, first read is x 0
    task automatic read_line;
        for (int x = 0; x < line_len; x++) begin
            @(posedge clk); // Entry at pix_x read and cleared here
            if (x < line_len - 1)
                pix_x <= 9'(x + 1);
            @(negedge clk);
            checks++;
            if (pix_out !== exp_line[x]) begin
                $display("Mismatch pix_out x=%03h expected %03h actual %03h",
                         x, exp_line[x], pix_out);
                errors++;
            end
        end
    endtask

    // Entries already read must come back blank
    task automatic reread_cleared;
        for (int x = 36; x <= 52; x++) begin
            @(posedge clk);
            if (x < 52)
                pix_x <= 9'(x);
            @(negedge clk);
            if (x > 36) begin
                checks++;
                if (pix_out !== 10'h000) begin
                    $display("Mismatch pix_out x=%03h expected %03h actual %03h (reread)",
                             x - 1, 10'h000, pix_out);
                    errors++;
                end
            end
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        cpu_we   = 1'b0;
        cpu_addr = '0;
        cpu_din  = '0;
        hstart   = 1'b0;
        vrender  = 9'd300;
        flip     = 1'b0;
        pix_x    = '0;
        errors   = 0;
        checks   = 0;
        cycles   = 0;
        void'($urandom(21173));
        $readmemh("obj_gfx.hex", gfx_ref);
        fill_cases();

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        for (int c = 0; c < n_cases; c++) begin
            load_case(c);
            build_expected(c);
            pulse_hstart(case_vr[c], case_flip[c]);
            run_line();
            pulse_hstart(9'd300, 1'b0); // Swap banks, no scan on this line
            read_line();
            reread_cleared();
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
